/* run_sim.sh */
#!/bin/sh
# build the bank scheduler testbench with Verilator and run it
# the run counts as passed only when the log holds the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing -Wno-fatal -f verilog.f --top-module bank_sched_tb \
   -o bank_sched_sim > build.log 2>&1 \
   && ./obj_dir/bank_sched_sim > sim.log 2>&1 \
   && grep -qx "TEST PASS" sim.log \
   && echo "simulation passed, see sim.log" \
   || { echo "simulation failed, see build.log and sim.log"; exit 1; }
exit 0

/* verification/bank_sched_tb.sv */
`default_nettype none
`timescale 1ns/1ns

module bank_sched_tb;

   localparam int RD_FIFO_NUM   = 4;
   localparam int WR_FIFO_NUM   = 3;
   localparam int RD_FIFO_DEPTH = 4;
   localparam int WR_FIFO_DEPTH = 2;
   localparam int NUM_REQ       = 120;                        // stays below the 7 bit tag range
   localparam int RST_CYCLES    = 10;
   localparam int MAX_CYCLES    = 20 * NUM_REQ + RST_CYCLES;
   localparam int BP_START      = 40;                         // accept count opening the stall
   localparam int BP_CYCLES     = 40;                         // issue port held off this long

   logic             clk;
   logic             rst_i;
   logic             req_valid_i;
   logic             req_ready_o;
   bs_pkg::bs_req_t  req_i;
   bs_pkg::bs_kind_e mode_i;
   logic             iss_valid_o;
   logic             iss_ready_i;
   bs_pkg::bs_req_t  iss_o;

   logic [31:0]      lcg_state;

   // reference model state filled by the monitor
   bs_pkg::bs_req_t  accepted [NUM_REQ];        // by index
   logic             issued_flag [NUM_REQ];
   int               order_q [8][NUM_REQ];      // indices per kind and row in accept order
   int               q_head [8];
   int               q_tail [8];
   int               accept_cnt;
   int               issue_cnt;
   int               cycle_cnt;
   logic             rst_tail;                  // first cycle after reset pending
   logic             held_valid;                // issue stalled last cycle
   bs_pkg::bs_req_t  held_iss;
   bs_pkg::bs_kind_e last_mode;
   logic             mode_flip;                 // mode moved since the last issue

   bank_sched_top #(
      .RD_FIFO_NUM   (RD_FIFO_NUM),
      .WR_FIFO_NUM   (WR_FIFO_NUM),
      .RD_FIFO_DEPTH (RD_FIFO_DEPTH),
      .WR_FIFO_DEPTH (WR_FIFO_DEPTH)
   ) i_bank_sched_top (
      .clk         (clk),
      .rst_i       (rst_i),
      .req_valid_i (req_valid_i),
      .req_ready_o (req_ready_o),
      .req_i       (req_i),
      .mode_i      (mode_i),
      .iss_valid_o (iss_valid_o),
      .iss_ready_i (iss_ready_i),
      .iss_o       (iss_o)
   );

   always #20 clk = ~clk;   // 40 ns period

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic int rand_below(input int n);
      logic [31:0] r;
      r = lcg_next();
      return int'(r[31:8] % n);   // low lcg bits are weak
   endfunction

   // four rows only so bursts form
   function automatic logic [bs_pkg::ROW_W-1:0] row_pick(input int k);
      case (k)
         0:       return 16'h0012;
         1:       return 16'h01a3;
         2:       return 16'h7f00;
         default: return 16'hbeef;
      endcase
   endfunction

   function automatic int row_slot(input logic [bs_pkg::ROW_W-1:0] row);
      for (int k = 0; k < 4; k++) begin
         if (row_pick(k) == row) begin
            return k;
         end
      end
      return -1;
   endfunction

   function automatic int queue_id(input bs_pkg::bs_kind_e kind,
                                   input logic [bs_pkg::ROW_W-1:0] row);
      int slot;
      slot = row_slot(row);
      if (slot < 0) begin
         return -1;
      end
      return (kind == bs_pkg::READ) ? 4 + slot : slot;
   endfunction

   // the only legal next issue of a kind and row is its oldest pending index
   function automatic int expected_index(input bs_pkg::bs_kind_e kind,
                                         input logic [bs_pkg::ROW_W-1:0] row);
      int q;
      q = queue_id(kind, row);
      if (q < 0 || q_head[q] == q_tail[q]) begin
         return -1;
      end
      return order_q[q][q_head[q]];
   endfunction

   function automatic bs_pkg::bs_req_t make_request(input int idx);
      bs_pkg::bs_req_t r;
      logic [31:0]     rnd;
      r.kind  = (rand_below(2) == 0) ? bs_pkg::READ : bs_pkg::WRITE;
      r.index = idx[bs_pkg::INDEX_W-1:0];
      r.row   = row_pick(rand_below(4));
      rnd     = lcg_next();
      r.col   = rnd[8 +: bs_pkg::COL_W];
      r.data  = rnd[31 -: bs_pkg::DATA_W];   // don't care for reads
      return r;
   endfunction

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("TEST FAIL");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         stop_run($sformatf("mismatch %s got %0h expected %0h", name, got, exp));
      end
   endtask

   // monitor and comparing process on pre-edge values
   always @(posedge clk) begin
      int              exp_idx;
      int              q;
      bs_pkg::bs_req_t acc;
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > MAX_CYCLES) begin
         stop_run($sformatf("timeout after %0d cycles, %0d of %0d requests issued",
                            cycle_cnt, issue_cnt, NUM_REQ));
      end else if (rst_i) begin
         if (cycle_cnt > 1) begin   // flops known after the first reset edge
            check_value("iss_valid_o", iss_valid_o, 1'b0);
            check_value("req_ready_o", req_ready_o, 1'b0);
         end
         rst_tail   = 1'b1;
         held_valid = 1'b0;
      end else begin
         if (rst_tail) begin
            check_value("iss_valid_o", iss_valid_o, 1'b0);
            check_value("req_ready_o", req_ready_o, 1'b0);   // state not known yet
            rst_tail = 1'b0;
         end
         if (held_valid) begin   // stalled issue must hold
            check_value("iss_valid_o", iss_valid_o, 1'b1);
            check_value("iss_o", iss_o, held_iss);
         end
         if (mode_i != last_mode) begin
            mode_flip = 1'b1;
         end
         last_mode = mode_i;
         if (iss_valid_o && iss_ready_i) begin
            if (int'(iss_o.index) >= accept_cnt || issued_flag[iss_o.index]) begin
               stop_run($sformatf("index %0h issued twice or never accepted", iss_o.index));
            end else begin
               acc = accepted[iss_o.index];
               check_value("iss_o.kind", iss_o.kind, acc.kind);
               check_value("iss_o.row", iss_o.row, acc.row);
               check_value("iss_o.col", iss_o.col, acc.col);
               if (acc.kind == bs_pkg::WRITE) begin
                  check_value("iss_o.data", iss_o.data, acc.data);
               end
               exp_idx = expected_index(iss_o.kind, iss_o.row);
               check_value("iss_o.index", iss_o.index, exp_idx);   // row order
               if (!mode_flip) begin
                  check_value("iss_o.kind", iss_o.kind, mode_i);
               end
               mode_flip = 1'b0;
               q = queue_id(iss_o.kind, iss_o.row);
               q_head[q] = q_head[q] + 1;
               issued_flag[iss_o.index] = 1'b1;
               issue_cnt = issue_cnt + 1;
            end
         end
         if (req_valid_i && req_ready_o) begin
            accepted[accept_cnt] = req_i;
            q = queue_id(req_i.kind, req_i.row);
            order_q[q][q_tail[q]] = accept_cnt;
            q_tail[q] = q_tail[q] + 1;
            accept_cnt = accept_cnt + 1;
         end
         held_valid = iss_valid_o && !iss_ready_i;
         held_iss   = iss_o;
      end
   end

   // stimulus
   initial begin
      bs_pkg::bs_req_t cur_req;
      int              next_idx;
      int              mode_left;
      int              stall_left;
      logic            stall_started;
      logic            refused;
      clk         = 1'b0;
      rst_i       = 1'b1;
      req_valid_i = 1'b0;
      req_i       = '0;
      mode_i      = bs_pkg::READ;
      iss_ready_i = 1'b0;
      lcg_state   = 32'h27ef_d85b;
      accept_cnt  = 0;
      issue_cnt   = 0;
      cycle_cnt   = 0;
      rst_tail    = 1'b0;
      held_valid  = 1'b0;
      held_iss    = '0;
      last_mode   = bs_pkg::READ;
      mode_flip   = 1'b0;
      for (int i = 0; i < NUM_REQ; i++) begin
         issued_flag[i] = 1'b0;
      end
      for (int i = 0; i < 8; i++) begin
         q_head[i] = 0;
         q_tail[i] = 0;
      end
      next_idx      = 0;
      mode_left     = 8;
      stall_left    = 0;
      stall_started = 1'b0;
      refused       = 1'b0;
      cur_req       = make_request(0);
      repeat (RST_CYCLES) @(posedge clk);
      rst_i <= 1'b0;
      forever begin
         if (req_valid_i && req_ready_o) begin
            next_idx = next_idx + 1;
            if (next_idx < NUM_REQ) begin
               cur_req = make_request(next_idx);
            end
         end
         if (stall_left > 0 && req_valid_i && !req_ready_o) begin
            refused = 1'b1;
         end
         // mode phases of random length
         mode_left = mode_left - 1;
         if (mode_left == 0) begin
            mode_i    <= (mode_i == bs_pkg::READ) ? bs_pkg::WRITE : bs_pkg::READ;
            mode_left = 4 + rand_below(28);
         end
         if (!stall_started && next_idx >= BP_START) begin
            stall_started = 1'b1;
            stall_left    = BP_CYCLES;
         end
         if (stall_left > 0) begin
            stall_left  = stall_left - 1;
            iss_ready_i <= 1'b0;
            if (stall_left == 0 && !refused) begin
               stop_run("requests were never refused while the issue port stalled");
            end
         end else begin
            iss_ready_i <= (rand_below(4) != 0);
         end
         if (next_idx >= NUM_REQ) begin
            req_valid_i <= 1'b0;
         end else if (!(req_valid_i && !req_ready_o)) begin   // refused request holds
            req_i       <= cur_req;
            req_valid_i <= (stall_left > 0) || (rand_below(4) != 0);
         end
         @(negedge clk);   // monitor is done with this edge
         if (issue_cnt >= NUM_REQ) begin
            break;
         end
         @(posedge clk);
      end
      $display("TEST PASS");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
verilog/bs_pkg.sv
verilog/req_fifo.sv
verilog/req_selector.sv
verilog/bank_scheduler.sv
verilog/bank_sched_top.sv
verification/bank_sched_tb.sv

/* verilog/bank_sched_top.sv */
`default_nettype none
`timescale 1ns/1ns

// single bank request scheduler, fifos plus selector plus scheduler
module bank_sched_top #(
   parameter  int RD_FIFO_NUM   = 4,
   parameter  int WR_FIFO_NUM   = 3,
   parameter  int RD_FIFO_DEPTH = 4,
   parameter  int WR_FIFO_DEPTH = 2,
   localparam int FIFO_NUM      = RD_FIFO_NUM + WR_FIFO_NUM
) (
   input  wire                    clk,
   input  wire                    rst_i,
   input  wire                    req_valid_i,
   output logic                   req_ready_o,
   input  wire bs_pkg::bs_req_t   req_i,
   input  wire bs_pkg::bs_kind_e  mode_i,
   output logic                   iss_valid_o,
   input  wire                    iss_ready_i,
   output bs_pkg::bs_req_t        iss_o
);

   wire [FIFO_NUM-1:0]                    fifo_push;    // selector to fifos
   wire [FIFO_NUM-1:0]                    fifo_pop;     // scheduler to fifos
   wire [FIFO_NUM-1:0]                    fifo_empty;
   wire [FIFO_NUM-1:0]                    fifo_full;
   wire [FIFO_NUM-1:0][bs_pkg::ROW_W-1:0] fifo_row;
   wire bs_pkg::bs_req_t [FIFO_NUM-1:0]   fifo_head;

   // read fifos sit at indices 0 .. RD_FIFO_NUM-1
   for (genvar g = 0; g < RD_FIFO_NUM; g++) begin : rd_fifo
      req_fifo #(.DEPTH(RD_FIFO_DEPTH)) i_req_fifo (
         .clk     (clk),
         .rst_i   (rst_i),
         .push_i  (fifo_push[g]),
         .data_i  (req_i),
         .pop_i   (fifo_pop[g]),
         .head_o  (fifo_head[g]),
         .empty_o (fifo_empty[g]),
         .full_o  (fifo_full[g]),
         .row_o   (fifo_row[g])
      );
   end

   // write fifos stacked above
   for (genvar g = 0; g < WR_FIFO_NUM; g++) begin : wr_fifo
      req_fifo #(.DEPTH(WR_FIFO_DEPTH)) i_req_fifo (
         .clk     (clk),
         .rst_i   (rst_i),
         .push_i  (fifo_push[RD_FIFO_NUM + g]),
         .data_i  (req_i),
         .pop_i   (fifo_pop[RD_FIFO_NUM + g]),
         .head_o  (fifo_head[RD_FIFO_NUM + g]),
         .empty_o (fifo_empty[RD_FIFO_NUM + g]),
         .full_o  (fifo_full[RD_FIFO_NUM + g]),
         .row_o   (fifo_row[RD_FIFO_NUM + g])
      );
   end

   req_selector #(
      .RD_FIFO_NUM (RD_FIFO_NUM),
      .WR_FIFO_NUM (WR_FIFO_NUM)
   ) i_req_selector (
      .clk          (clk),
      .rst_i        (rst_i),
      .req_valid_i  (req_valid_i),
      .req_i        (req_i),
      .req_ready_o  (req_ready_o),
      .push_o       (fifo_push),
      .fifo_empty_i (fifo_empty),
      .fifo_full_i  (fifo_full),
      .fifo_row_i   (fifo_row)
   );

   bank_scheduler #(
      .RD_FIFO_NUM (RD_FIFO_NUM),
      .WR_FIFO_NUM (WR_FIFO_NUM)
   ) i_bank_scheduler (
      .clk          (clk),
      .rst_i        (rst_i),
      .mode_i       (mode_i),
      .fifo_empty_i (fifo_empty),
      .fifo_head_i  (fifo_head),
      .pop_o        (fifo_pop),
      .iss_valid_o  (iss_valid_o),
      .iss_ready_i  (iss_ready_i),
      .iss_o        (iss_o)
   );

endmodule

`default_nettype wire

/* verilog/bank_scheduler.sv */
`default_nettype none
`timescale 1ns/1ns

// drains one fifo at a time as a row burst into the issue register
module bank_scheduler #(
   parameter  int RD_FIFO_NUM = 4,
   parameter  int WR_FIFO_NUM = 3,
   localparam int FIFO_NUM    = RD_FIFO_NUM + WR_FIFO_NUM
) (
   input  wire                                clk,
   input  wire                                rst_i,
   input  wire bs_pkg::bs_kind_e              mode_i,         // controller mode
   input  wire  [FIFO_NUM-1:0]                fifo_empty_i,
   input  wire bs_pkg::bs_req_t [FIFO_NUM-1:0] fifo_head_i,
   output logic [FIFO_NUM-1:0]                pop_o,          // one-hot
   output logic                               iss_valid_o,
   input  wire                                iss_ready_i,
   output bs_pkg::bs_req_t                    iss_o
);

   localparam int IDX_W = (FIFO_NUM > 1) ? $clog2(FIFO_NUM) : 1;

   bs_pkg::sch_state_e state_q;
   logic [IDX_W-1:0]   cur_q;        // claimed fifo
   bs_pkg::bs_kind_e   kind_q;       // mode at claim time
   logic [IDX_W-1:0]   rd_last_q;    // last claimed, offset in read group
   logic [IDX_W-1:0]   wr_last_q;    // last claimed, offset in write group
   logic               iss_valid_q;
   bs_pkg::bs_req_t    iss_q;        // issue register
   logic               iss_free;     // empty or being taken
   logic               found;
   logic [IDX_W-1:0]   found_idx;
   logic               pop_en;
   logic [IDX_W-1:0]   pop_idx;

   assign iss_free = ~iss_valid_q | iss_ready_i;

   // round-robin search inside the mode's group
   always_comb begin
      int grp_base;
      int grp_num;
      int last_off;
      int pos;
      found     = 1'b0;
      found_idx = '0;
      pos       = 0;
      if (mode_i == bs_pkg::READ) begin
         grp_base = 0;
         grp_num  = RD_FIFO_NUM;
         last_off = int'(rd_last_q);
      end else begin
         grp_base = RD_FIFO_NUM;
         grp_num  = WR_FIFO_NUM;
         last_off = int'(wr_last_q);
      end
      for (int k = 1; k <= FIFO_NUM; k++) begin
         if (k <= grp_num) begin
            pos = last_off + k;          // start after last claim
            if (pos >= grp_num) begin
               pos = pos - grp_num;      // wrap in group
            end
            if (!found && !fifo_empty_i[grp_base + pos]) begin
               found     = 1'b1;
               found_idx = IDX_W'(grp_base + pos);
            end
         end
      end
   end

   // pop decision
   always_comb begin
      pop_en  = 1'b0;
      pop_idx = cur_q;
      case (state_q)
         bs_pkg::SCH_IDLE: begin
            // claim and pop in one go when the register has room
            if (found && iss_free) begin
               pop_en  = 1'b1;
               pop_idx = found_idx;
            end
         end
         bs_pkg::SCH_BURST: begin
            if (!fifo_empty_i[cur_q] && mode_i == kind_q && iss_free) begin
               pop_en = 1'b1;
            end
         end
         default: ;
      endcase
      pop_o = '0;
      if (pop_en) begin
         pop_o[pop_idx] = 1'b1;
      end
   end

   // fsm and claim bookkeeping
   always_ff @(posedge clk) begin
      if (rst_i) begin
         state_q   <= bs_pkg::SCH_IDLE;
         cur_q     <= '0;
         kind_q    <= bs_pkg::READ;
         rd_last_q <= IDX_W'(RD_FIFO_NUM - 1);   // first search starts at 0
         wr_last_q <= IDX_W'(WR_FIFO_NUM - 1);
      end else begin
         case (state_q)
            bs_pkg::SCH_IDLE: begin
               if (found) begin
                  state_q <= bs_pkg::SCH_BURST;
                  cur_q   <= found_idx;
                  kind_q  <= mode_i;
                  if (mode_i == bs_pkg::READ) begin
                     rd_last_q <= found_idx;
                  end else begin
                     wr_last_q <= found_idx - IDX_W'(RD_FIFO_NUM);
                  end
               end
            end
            bs_pkg::SCH_BURST: begin
               // burst ends on drain or mode flip
               if (fifo_empty_i[cur_q] || mode_i != kind_q) begin
                  state_q <= bs_pkg::SCH_IDLE;
               end
            end
            default: state_q <= bs_pkg::SCH_IDLE;
         endcase
      end
   end

   // issue valid, loaded entry waits for ready even across mode change
   always_ff @(posedge clk) begin
      if (rst_i) begin
         iss_valid_q <= 1'b0;
      end else if (pop_en) begin
         iss_valid_q <= 1'b1;
      end else if (iss_ready_i) begin
         iss_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (pop_en) begin
         iss_q <= fifo_head_i[pop_idx];   // stable until taken
      end
   end

   assign iss_valid_o = iss_valid_q;
   assign iss_o       = iss_q;

endmodule

`default_nettype wire

/* verilog/bs_pkg.sv */
`default_nettype none

package bs_pkg;

   // request field widths
   localparam int ROW_W   = 16;   // row address
   localparam int COL_W   = 10;   // column address
   localparam int DATA_W  = 16;   // write data
   localparam int INDEX_W = 7;    // request tag

   // request kind, doubles as controller mode
   typedef enum logic {
      WRITE = 1'b0,
      READ  = 1'b1
   } bs_kind_e;

   // one request as it travels through the bank scheduler
   // 1 + 7 + 16 + 10 + 16 = 50 bits
   typedef struct packed {
      bs_kind_e             kind;    // read or write
      logic [INDEX_W-1:0]   index;   // tag, identifies the request on the way back
      logic [ROW_W-1:0]     row;     // row address, decides fifo grouping
      logic [COL_W-1:0]     col;     // column address
      logic [DATA_W-1:0]    data;    // write payload, ignored for reads
   } bs_req_t;

   // scheduler fsm
   typedef enum logic {
      SCH_IDLE  = 1'b0,    // nothing claimed
      SCH_BURST = 1'b1     // draining the claimed fifo
   } sch_state_e;

endpackage

`default_nettype wire

/* verilog/req_fifo.sv */
`default_nettype none
`timescale 1ns/1ns

// circular request buffer, one row per fifo
module req_fifo #(
   parameter int DEPTH = 4
) (
   input  wire                      clk,
   input  wire                      rst_i,
   input  wire                      push_i,     // write data_i on this edge
   input  wire bs_pkg::bs_req_t     data_i,
   input  wire                      pop_i,      // drop head on this edge
   output bs_pkg::bs_req_t          head_o,     // oldest entry
   output logic                     empty_o,
   output logic                     full_o,
   output logic [bs_pkg::ROW_W-1:0] row_o       // row held, valid when not empty
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   bs_pkg::bs_req_t          mem [DEPTH];   // storage
   logic [PTR_W-1:0]         wr_ptr_q;
   logic [PTR_W-1:0]         rd_ptr_q;
   logic [CNT_W-1:0]         count_q;       // entries held
   logic [bs_pkg::ROW_W-1:0] row_q;         // row of last push
   logic                     do_push;
   logic                     do_pop;

   // pointer step with wrap at DEPTH, depth need not be a power of two
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign empty_o = (count_q == '0);
   assign full_o  = (count_q == CNT_W'(DEPTH));

   // guard against overrun and underrun
   assign do_push = push_i & ~full_o;
   assign do_pop  = pop_i & ~empty_o;

   assign head_o = mem[rd_ptr_q];   // first-word fall-through
   assign row_o  = row_q;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr_q <= ptr_inc(wr_ptr_q);
         end
         if (do_pop) begin
            rd_ptr_q <= ptr_inc(rd_ptr_q);
         end
         // push with pop keeps count
         if (do_push && !do_pop) begin
            count_q <= count_q + 1'b1;
         end else if (do_pop && !do_push) begin
            count_q <= count_q - 1'b1;
         end
      end
   end

   // payload side
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr_q] <= data_i;
         row_q         <= data_i.row;   // selector never mixes rows
      end
   end

endmodule

`default_nettype wire

/* verilog/req_selector.sv */
`default_nettype none
`timescale 1ns/1ns

// places each incoming request into a fifo of its kind and row
module req_selector #(
   parameter  int RD_FIFO_NUM = 4,
   parameter  int WR_FIFO_NUM = 3,
   localparam int FIFO_NUM    = RD_FIFO_NUM + WR_FIFO_NUM
) (
   input  wire                                     clk,
   input  wire                                     rst_i,
   input  wire                                     req_valid_i,
   input  wire bs_pkg::bs_req_t                    req_i,
   output logic                                    req_ready_o,
   output logic [FIFO_NUM-1:0]                     push_o,        // one-hot
   input  wire  [FIFO_NUM-1:0]                     fifo_empty_i,
   input  wire  [FIFO_NUM-1:0]                     fifo_full_i,
   input  wire  [FIFO_NUM-1:0][bs_pkg::ROW_W-1:0]  fifo_row_i
);

   logic                rst_done_q;   // fifo state known after first cycle
   logic [FIFO_NUM-1:0] kind_mask;    // fifos of the request's kind
   logic [FIFO_NUM-1:0] row_eq;       // non-empty and holding req row
   logic [FIFO_NUM-1:0] hit_mask;     // same row, room left
   logic [FIFO_NUM-1:0] free_mask;    // empty, right kind
   logic [FIFO_NUM-1:0] hit_sel;
   logic [FIFO_NUM-1:0] free_sel;
   logic [FIFO_NUM-1:0] sel_mask;
   logic                row_blk;      // row already sits in a full fifo

   always_ff @(posedge clk) begin
      if (rst_i) begin
         rst_done_q <= 1'b0;
      end else begin
         rst_done_q <= 1'b1;
      end
   end

   // per fifo qualifiers
   always_comb begin
      for (int i = 0; i < FIFO_NUM; i++) begin
         // read fifos first, write fifos above them
         if (i < RD_FIFO_NUM) begin
            kind_mask[i] = (req_i.kind == bs_pkg::READ);
         end else begin
            kind_mask[i] = (req_i.kind == bs_pkg::WRITE);
         end
         row_eq[i] = ~fifo_empty_i[i] & (fifo_row_i[i] == req_i.row);
      end
   end

   assign hit_mask  = kind_mask & row_eq & ~fifo_full_i;
   assign free_mask = kind_mask & fifo_empty_i;

   // a full fifo of this row blocks the spill so per-row order holds
   assign row_blk = |(kind_mask & row_eq & fifo_full_i);

   // isolate lowest set bit
   assign hit_sel  = hit_mask & (~hit_mask + 1'b1);
   assign free_sel = free_mask & (~free_mask + 1'b1);

   always_comb begin
      if (|hit_mask) begin
         sel_mask = hit_sel;        // join the open row
      end else if (row_blk) begin
         sel_mask = '0;             // wait for the full fifo to drain
      end else begin
         sel_mask = free_sel;       // open a new fifo, may be none
      end
   end

   assign req_ready_o = rst_done_q & (|sel_mask);
   assign push_o      = (req_valid_i && req_ready_o) ? sel_mask : '0;

endmodule

`default_nettype wire
